/* rtl/atop_filter_consts.svh */
`ifndef ATOP_FILTER_CONSTS_SVH
`define ATOP_FILTER_CONSTS_SVH

// Bus field widths
`define ATOP_ID_W   4
`define ATOP_ADDR_W 32
`define ATOP_DATA_W 32

// Default limit on downstream write bursts with W data still open
`define ATOP_MAX_WRITE_TXNS 4

// Values of atop[5:4]
`define ATOP_KIND_NONE  2'd0
`define ATOP_KIND_STORE 2'd1

// B and R response codes
`define ATOP_RESP_OKAY   2'd0
`define ATOP_RESP_SLVERR 2'd2

`endif

/* rtl/atop_filter_pkg.sv */
`include "atop_filter_consts.svh"

package atop_filter_pkg;

  // Channel payload fields
  typedef logic [`ATOP_ID_W-1:0]   id_t;
  typedef logic [`ATOP_ADDR_W-1:0] addr_t;
  typedef logic [`ATOP_DATA_W-1:0] data_t;
  // Burst length minus one
  typedef logic [7:0]              len_t;
  typedef logic [5:0]              atop_t;
  typedef logic [1:0]              bresp_t;

  // Write side of the filter
  typedef enum logic [2:0] {
    W_FEEDTHROUGH,
    BLOCK_AW,
    ABSORB_W,
    INJECT_B,
    WAIT_R
  } w_state_e;

  // Read side of the filter
  typedef enum logic {
    R_FEEDTHROUGH,
    INJECT_R
  } r_state_e;

endpackage

/* rtl/atop_decode.sv */
`include "atop_filter_consts.svh"

module atop_decode (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   aw_valid_i,
  input  atop_filter_pkg::id_t   aw_id_i,
  input  atop_filter_pkg::len_t  aw_len_i,
  input  atop_filter_pkg::atop_t aw_atop_i,
  input  logic                   atop_take_i,
  output logic                   aw_is_atop_o,
  output atop_filter_pkg::id_t   atop_id_o,
  output logic                   rcmd_push_o,
  output atop_filter_pkg::len_t  rcmd_len_o
);
  import atop_filter_pkg::*;

  logic [1:0] kind;
  logic       is_atomic;
  logic       needs_r;
  id_t        id_q;

  // Kind field of the AW atop
  assign kind      = aw_atop_i[5:4];
  assign is_atomic = (kind != `ATOP_KIND_NONE);
  // Everything but an atomic store returns read data
  assign needs_r   = is_atomic && (kind != `ATOP_KIND_STORE);

  assign aw_is_atop_o = aw_valid_i && is_atomic;

  // R command goes out in the same cycle as the absorbed AW
  assign rcmd_push_o = atop_take_i && needs_r;
  assign rcmd_len_o  = aw_len_i;

  // ID for the injected B and R
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (atop_take_i) begin
      id_q <= aw_id_i;
    end
  end

  assign atop_id_o = id_q;

endmodule

/* rtl/atop_write_ctrl.sv */
`include "atop_filter_consts.svh"

module atop_write_ctrl #(
  parameter int unsigned MaxWriteTxns = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // AW control
  input  logic                    slv_aw_valid_i,
  input  logic                    aw_is_atop_i,
  input  logic                    mst_aw_ready_i,
  output logic                    slv_aw_ready_o,
  output logic                    mst_aw_valid_o,
  // W control
  input  logic                    slv_w_valid_i,
  input  logic                    slv_w_last_i,
  input  logic                    mst_w_ready_i,
  output logic                    slv_w_ready_o,
  output logic                    mst_w_valid_o,
  // B channel
  input  logic                    slv_b_ready_i,
  input  logic                    mst_b_valid_i,
  input  atop_filter_pkg::id_t    mst_b_id_i,
  input  atop_filter_pkg::bresp_t mst_b_resp_i,
  output logic                    slv_b_valid_o,
  output atop_filter_pkg::id_t    slv_b_id_o,
  output atop_filter_pkg::bresp_t slv_b_resp_o,
  output logic                    mst_b_ready_o,
  // Links to decode and read side
  input  atop_filter_pkg::id_t    atop_id_i,
  input  logic                    rcmd_pending_i,
  output logic                    atop_take_o
);
  import atop_filter_pkg::*;

  // Counter holds 0 up to MaxWriteTxns
  localparam int unsigned CntW = $clog2(MaxWriteTxns + 1);

  logic [CntW-1:0] cnt_q, cnt_d;
  w_state_e        state_q, state_d;
  logic            aw_below_max;
  logic            w_outstanding;

  assign aw_below_max  = (cnt_q < CntW'(MaxWriteTxns));
  assign w_outstanding = (cnt_q != '0);

  always_comb begin
    // AW and W closed unless a state opens them
    mst_aw_valid_o = 1'b0;
    slv_aw_ready_o = 1'b0;
    mst_w_valid_o  = 1'b0;
    slv_w_ready_o  = 1'b0;
    // B passes through by default
    slv_b_valid_o  = mst_b_valid_i;
    slv_b_id_o     = mst_b_id_i;
    slv_b_resp_o   = mst_b_resp_i;
    mst_b_ready_o  = slv_b_ready_i;
    atop_take_o    = 1'b0;
    state_d        = state_q;

    unique case (state_q)
      W_FEEDTHROUGH: begin
        if (aw_below_max) begin
          mst_aw_valid_o = slv_aw_valid_i;
          slv_aw_ready_o = mst_aw_ready_i;
        end
        // W may only follow its own AW
        if (w_outstanding) begin
          mst_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mst_w_ready_i;
        end
        // Atomic AW is swallowed here, never reaching the slave
        if (aw_is_atop_i) begin
          mst_aw_valid_o = 1'b0;
          slv_aw_ready_o = 1'b1;
          atop_take_o    = 1'b1;
          if (w_outstanding) begin
            // Older bursts first finish their W data
            state_d = BLOCK_AW;
          end else begin
            mst_w_valid_o = 1'b0;
            slv_w_ready_o = 1'b1;
            if (slv_w_valid_i && slv_w_last_i) begin
              state_d = INJECT_B;
            end else begin
              state_d = ABSORB_W;
            end
          end
        end
      end

      BLOCK_AW: begin
        if (w_outstanding) begin
          mst_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mst_w_ready_i;
        end else begin
          // Next burst on W belongs to the atomic AW
          slv_w_ready_o = 1'b1;
          if (slv_w_valid_i && slv_w_last_i) begin
            state_d = INJECT_B;
          end else begin
            state_d = ABSORB_W;
          end
        end
      end

      ABSORB_W: begin
        slv_w_ready_o = 1'b1;
        if (slv_w_valid_i && slv_w_last_i) begin
          state_d = INJECT_B;
        end
      end

      INJECT_B: begin
        // Hold off downstream B while the error response goes up
        mst_b_ready_o = 1'b0;
        slv_b_valid_o = 1'b1;
        slv_b_id_o    = atop_id_i;
        slv_b_resp_o  = `ATOP_RESP_SLVERR;
        if (slv_b_ready_i) begin
          if (rcmd_pending_i) begin
            state_d = WAIT_R;
          end else begin
            state_d = W_FEEDTHROUGH;
          end
        end
      end

      WAIT_R: begin
        // R beats of this atomic still in flight
        if (!rcmd_pending_i) begin
          state_d = W_FEEDTHROUGH;
        end
      end

      default: state_d = W_FEEDTHROUGH;
    endcase
  end

  // Up on downstream AW, down on downstream last W
  always_comb begin
    cnt_d = cnt_q;
    if (mst_aw_valid_o && mst_aw_ready_i) begin
      cnt_d = cnt_d + CntW'(1);
    end
    if (mst_w_valid_o && mst_w_ready_i && slv_w_last_i) begin
      cnt_d = cnt_d - CntW'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= W_FEEDTHROUGH;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  a_cnt_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CntW'(MaxWriteTxns))
    else $error("write burst counter above limit");

  // Decode flag and downstream AW valid are mutually exclusive
  a_no_atop_down: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_is_atop_i |-> !mst_aw_valid_o)
    else $error("atomic AW forwarded downstream");

endmodule

/* rtl/atop_read_inject.sv */
`include "atop_filter_consts.svh"

module atop_read_inject (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // R command from decode
  input  logic                    rcmd_push_i,
  input  atop_filter_pkg::len_t   rcmd_len_i,
  input  atop_filter_pkg::id_t    atop_id_i,
  // Downstream R
  input  logic                    mst_r_valid_i,
  input  atop_filter_pkg::id_t    mst_r_id_i,
  input  atop_filter_pkg::data_t  mst_r_data_i,
  input  atop_filter_pkg::bresp_t mst_r_resp_i,
  input  logic                    mst_r_last_i,
  output logic                    mst_r_ready_o,
  // Upstream R
  input  logic                    slv_r_ready_i,
  output logic                    slv_r_valid_o,
  output atop_filter_pkg::id_t    slv_r_id_o,
  output atop_filter_pkg::data_t  slv_r_data_o,
  output atop_filter_pkg::bresp_t slv_r_resp_o,
  output logic                    slv_r_last_o,
  // Level toward write side
  output logic                    rcmd_pending_o
);
  import atop_filter_pkg::*;

  logic     cmd_valid_q, cmd_valid_d;
  len_t     cmd_len_q;
  len_t     beats_q, beats_d;
  r_state_e state_q, state_d;

  // Command stays stored until its last beat is taken
  assign rcmd_pending_o = cmd_valid_q;

  always_comb begin
    // Downstream R passes through by default
    slv_r_valid_o = mst_r_valid_i;
    slv_r_id_o    = mst_r_id_i;
    slv_r_data_o  = mst_r_data_i;
    slv_r_resp_o  = mst_r_resp_i;
    slv_r_last_o  = mst_r_last_i;
    mst_r_ready_o = slv_r_ready_i;
    cmd_valid_d   = cmd_valid_q;
    beats_d       = beats_q;
    state_d       = state_q;

    if (rcmd_push_i) begin
      cmd_valid_d = 1'b1;
    end

    unique case (state_q)
      R_FEEDTHROUGH: begin
        // No ordering against other IDs, so start right away
        if (cmd_valid_q) begin
          beats_d = cmd_len_q;
          state_d = INJECT_R;
        end
      end

      INJECT_R: begin
        mst_r_ready_o = 1'b0;
        slv_r_valid_o = 1'b1;
        slv_r_id_o    = atop_id_i;
        slv_r_data_o  = '0;
        slv_r_resp_o  = `ATOP_RESP_SLVERR;
        slv_r_last_o  = (beats_q == '0);
        if (slv_r_ready_i) begin
          if (beats_q == '0) begin
            cmd_valid_d = 1'b0;
            state_d     = R_FEEDTHROUGH;
          end else begin
            beats_d = beats_q - 8'd1;
          end
        end
      end

      default: state_d = R_FEEDTHROUGH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_valid_q <= 1'b0;
      beats_q     <= '0;
      state_q     <= R_FEEDTHROUGH;
    end else begin
      cmd_valid_q <= cmd_valid_d;
      beats_q     <= beats_d;
      state_q     <= state_d;
    end
  end

  // Beat count of the stored command
  always_ff @(posedge clk_i) begin
    if (rcmd_push_i) begin
      cmd_len_q <= rcmd_len_i;
    end
  end

  // Write side must wait for the previous command to drain
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rcmd_push_i |-> !cmd_valid_q)
    else $error("R command pushed while one is stored");

endmodule

/* rtl/atop_filter_top.sv */
`include "atop_filter_consts.svh"

module atop_filter_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Upstream AW
  input  logic                    slv_aw_valid_i,
  output logic                    slv_aw_ready_o,
  input  atop_filter_pkg::id_t    slv_aw_id_i,
  input  atop_filter_pkg::addr_t  slv_aw_addr_i,
  input  atop_filter_pkg::len_t   slv_aw_len_i,
  input  atop_filter_pkg::atop_t  slv_aw_atop_i,
  // Upstream W
  input  logic                    slv_w_valid_i,
  output logic                    slv_w_ready_o,
  input  atop_filter_pkg::data_t  slv_w_data_i,
  input  logic                    slv_w_last_i,
  // Upstream B
  output logic                    slv_b_valid_o,
  input  logic                    slv_b_ready_i,
  output atop_filter_pkg::id_t    slv_b_id_o,
  output atop_filter_pkg::bresp_t slv_b_resp_o,
  // Upstream AR
  input  logic                    slv_ar_valid_i,
  output logic                    slv_ar_ready_o,
  input  atop_filter_pkg::id_t    slv_ar_id_i,
  input  atop_filter_pkg::addr_t  slv_ar_addr_i,
  input  atop_filter_pkg::len_t   slv_ar_len_i,
  // Upstream R
  output logic                    slv_r_valid_o,
  input  logic                    slv_r_ready_i,
  output atop_filter_pkg::id_t    slv_r_id_o,
  output atop_filter_pkg::data_t  slv_r_data_o,
  output atop_filter_pkg::bresp_t slv_r_resp_o,
  output logic                    slv_r_last_o,
  // Downstream AW
  output logic                    mst_aw_valid_o,
  input  logic                    mst_aw_ready_i,
  output atop_filter_pkg::id_t    mst_aw_id_o,
  output atop_filter_pkg::addr_t  mst_aw_addr_o,
  output atop_filter_pkg::len_t   mst_aw_len_o,
  output atop_filter_pkg::atop_t  mst_aw_atop_o,
  // Downstream W
  output logic                    mst_w_valid_o,
  input  logic                    mst_w_ready_i,
  output atop_filter_pkg::data_t  mst_w_data_o,
  output logic                    mst_w_last_o,
  // Downstream B
  input  logic                    mst_b_valid_i,
  output logic                    mst_b_ready_o,
  input  atop_filter_pkg::id_t    mst_b_id_i,
  input  atop_filter_pkg::bresp_t mst_b_resp_i,
  // Downstream AR
  output logic                    mst_ar_valid_o,
  input  logic                    mst_ar_ready_i,
  output atop_filter_pkg::id_t    mst_ar_id_o,
  output atop_filter_pkg::addr_t  mst_ar_addr_o,
  output atop_filter_pkg::len_t   mst_ar_len_o,
  // Downstream R
  input  logic                    mst_r_valid_i,
  output logic                    mst_r_ready_o,
  input  atop_filter_pkg::id_t    mst_r_id_i,
  input  atop_filter_pkg::data_t  mst_r_data_i,
  input  atop_filter_pkg::bresp_t mst_r_resp_i,
  input  logic                    mst_r_last_i
);
  import atop_filter_pkg::*;

  logic aw_is_atop;
  logic atop_take;
  id_t  atop_id;
  logic rcmd_push;
  len_t rcmd_len;
  logic rcmd_pending;

  // AW payload with atop always cleared downstream
  assign mst_aw_id_o   = slv_aw_id_i;
  assign mst_aw_addr_o = slv_aw_addr_i;
  assign mst_aw_len_o  = slv_aw_len_i;
  assign mst_aw_atop_o = '0;

  // W payload, valid and ready go through the write FSM
  assign mst_w_data_o = slv_w_data_i;
  assign mst_w_last_o = slv_w_last_i;

  // AR untouched
  assign mst_ar_valid_o = slv_ar_valid_i;
  assign slv_ar_ready_o = mst_ar_ready_i;
  assign mst_ar_id_o    = slv_ar_id_i;
  assign mst_ar_addr_o  = slv_ar_addr_i;
  assign mst_ar_len_o   = slv_ar_len_i;

  atop_decode u_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .aw_valid_i   (slv_aw_valid_i),
    .aw_id_i      (slv_aw_id_i),
    .aw_len_i     (slv_aw_len_i),
    .aw_atop_i    (slv_aw_atop_i),
    .atop_take_i  (atop_take),
    .aw_is_atop_o (aw_is_atop),
    .atop_id_o    (atop_id),
    .rcmd_push_o  (rcmd_push),
    .rcmd_len_o   (rcmd_len)
  );

  atop_write_ctrl #(
    .MaxWriteTxns (`ATOP_MAX_WRITE_TXNS)
  ) u_write (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_valid_i (slv_aw_valid_i),
    .aw_is_atop_i   (aw_is_atop),
    .mst_aw_ready_i (mst_aw_ready_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_last_i   (slv_w_last_i),
    .mst_w_ready_i  (mst_w_ready_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .slv_b_ready_i  (slv_b_ready_i),
    .mst_b_valid_i  (mst_b_valid_i),
    .mst_b_id_i     (mst_b_id_i),
    .mst_b_resp_i   (mst_b_resp_i),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_id_o     (slv_b_id_o),
    .slv_b_resp_o   (slv_b_resp_o),
    .mst_b_ready_o  (mst_b_ready_o),
    .atop_id_i      (atop_id),
    .rcmd_pending_i (rcmd_pending),
    .atop_take_o    (atop_take)
  );

  atop_read_inject u_read (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rcmd_push_i    (rcmd_push),
    .rcmd_len_i     (rcmd_len),
    .atop_id_i      (atop_id),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_id_i     (mst_r_id_i),
    .mst_r_data_i   (mst_r_data_i),
    .mst_r_resp_i   (mst_r_resp_i),
    .mst_r_last_i   (mst_r_last_i),
    .mst_r_ready_o  (mst_r_ready_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_id_o     (slv_r_id_o),
    .slv_r_data_o   (slv_r_data_o),
    .slv_r_resp_o   (slv_r_resp_o),
    .slv_r_last_o   (slv_r_last_o),
    .rcmd_pending_o (rcmd_pending)
  );

endmodule

/* sim/atop_filter_tb.sv */
`include "atop_filter_consts.svh"

module atop_filter_tb;
  import atop_filter_pkg::*;

  localparam int ClkPeriod = 8;
  // Bursts issued over all tests, sets the watchdog
  localparam int NumBursts = 37;
  localparam int NumMixW   = 12;
  localparam int NumMixR   = 8;

  logic   clk_i;
  logic   rst_ni;
  logic   slv_aw_valid_i, slv_aw_ready_o;
  id_t    slv_aw_id_i;
  addr_t  slv_aw_addr_i;
  len_t   slv_aw_len_i;
  atop_t  slv_aw_atop_i;
  logic   slv_w_valid_i, slv_w_ready_o, slv_w_last_i;
  data_t  slv_w_data_i;
  logic   slv_b_valid_o, slv_b_ready_i;
  id_t    slv_b_id_o;
  bresp_t slv_b_resp_o;
  logic   slv_ar_valid_i, slv_ar_ready_o;
  id_t    slv_ar_id_i;
  addr_t  slv_ar_addr_i;
  len_t   slv_ar_len_i;
  logic   slv_r_valid_o, slv_r_ready_i, slv_r_last_o;
  id_t    slv_r_id_o;
  data_t  slv_r_data_o;
  bresp_t slv_r_resp_o;
  logic   mst_aw_valid_o, mst_aw_ready_i;
  id_t    mst_aw_id_o;
  addr_t  mst_aw_addr_o;
  len_t   mst_aw_len_o;
  atop_t  mst_aw_atop_o;
  logic   mst_w_valid_o, mst_w_ready_i, mst_w_last_o;
  data_t  mst_w_data_o;
  logic   mst_b_valid_i, mst_b_ready_o;
  id_t    mst_b_id_i;
  bresp_t mst_b_resp_i;
  logic   mst_ar_valid_o, mst_ar_ready_i;
  id_t    mst_ar_id_o;
  addr_t  mst_ar_addr_o;
  len_t   mst_ar_len_o;
  logic   mst_r_valid_i, mst_r_ready_o, mst_r_last_i;
  id_t    mst_r_id_i;
  data_t  mst_r_data_i;
  bresp_t mst_r_resp_i;

  integer seed;
  logic   hold_w;
  // Downstream AW handshakes minus downstream last-W handshakes
  int     w_open;
  int     s_wbeat;
  int     s_rbeat;
  data_t  s_mem [256];
  data_t  ref_mem [256];
  // W beats waiting upstream as {last, data}
  logic [32:0] w_q [$];
  // Expected B as {id, resp}, expected R as {id, last, resp, data}
  logic [5:0]  exp_b_q [$];
  logic [38:0] exp_r_q [$];
  // Slave side bursts as {id, addr, len}
  logic [43:0] s_aw_q [$];
  logic [43:0] s_ar_q [$];
  id_t         s_b_q [$];

  atop_filter_top DUT (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    stop_run();
  endtask

  // Memory start value, distinct for every word
  function automatic data_t fill_word(input int i);
    return {8'h5a, i[7:0], ~i[7:0], 8'h3c ^ i[7:0]};
  endfunction

  // Word index of one beat in the 256-word memory
  function automatic logic [7:0] widx(input addr_t a, input int beat);
    addr_t t;
    t = a + addr_t'(beat * 4);
    return t[9:2];
  endfunction

  // Called at edge + 1, returns at edge + 1 after the AW handshake
  task automatic write_burst(input id_t id, input addr_t addr, input len_t len,
                             input atop_t atop);
    logic [1:0] kind;
    data_t      d;
    int         b;
    kind           = atop[5:4];
    slv_aw_valid_i = 1'b1;
    slv_aw_id_i    = id;
    slv_aw_addr_i  = addr;
    slv_aw_len_i   = len;
    slv_aw_atop_i  = atop;
    @(posedge clk_i);
    while (!slv_aw_ready_o) @(posedge clk_i);
    for (b = 0; b <= int'(len); b++) begin
      d = $random(seed);
      w_q.push_back({(b == int'(len)), d});
      if (kind == `ATOP_KIND_NONE) begin
        ref_mem[widx(addr, b)] = d;
      end else if (kind != `ATOP_KIND_STORE) begin
        // Loads, swaps and compares get one SLVERR beat per W beat
        exp_r_q.push_back({id, (b == int'(len)), `ATOP_RESP_SLVERR, 32'h0});
      end
    end
    exp_b_q.push_back({id, (kind == `ATOP_KIND_NONE) ? `ATOP_RESP_OKAY : `ATOP_RESP_SLVERR});
    #1;
    slv_aw_valid_i = 1'b0;
  endtask

  task automatic read_burst(input id_t id, input addr_t addr, input len_t len);
    int b;
    slv_ar_valid_i = 1'b1;
    slv_ar_id_i    = id;
    slv_ar_addr_i  = addr;
    slv_ar_len_i   = len;
    @(posedge clk_i);
    while (!slv_ar_ready_o) @(posedge clk_i);
    for (b = 0; b <= int'(len); b++) begin
      exp_r_q.push_back({id, (b == int'(len)), `ATOP_RESP_OKAY, ref_mem[widx(addr, b)]});
    end
    #1;
    slv_ar_valid_i = 1'b0;
  endtask

  // Oldest expected B of this ID must match
  task automatic check_b(input id_t id, input bresp_t resp);
    int i;
    int idx;
    idx = -1;
    for (i = 0; i < exp_b_q.size(); i++) begin
      if (idx < 0 && exp_b_q[i][5:2] == id) idx = i;
    end
    if (idx < 0) begin
      report_mismatch($sformatf("unexpected B with id %0h", id));
    end else if (exp_b_q[idx][1:0] != resp) begin
      report_mismatch($sformatf("B id %0h resp %0d, expected %0d", id, resp,
                                exp_b_q[idx][1:0]));
    end else begin
      exp_b_q.delete(idx);
    end
  endtask

  task automatic check_r(input id_t id, input data_t data, input bresp_t resp,
                         input logic last);
    int i;
    int idx;
    idx = -1;
    for (i = 0; i < exp_r_q.size(); i++) begin
      if (idx < 0 && exp_r_q[i][38:35] == id) idx = i;
    end
    if (idx < 0) begin
      report_mismatch($sformatf("unexpected R beat with id %0h", id));
    end else if (exp_r_q[idx][34:0] != {last, resp, data}) begin
      report_mismatch($sformatf("R id %0h got last %0b resp %0d data %h, expected %h",
                                id, last, resp, data, exp_r_q[idx][34:0]));
    end else begin
      exp_r_q.delete(idx);
    end
  endtask

  // Wait until every expected response has arrived
  task automatic drain();
    while (exp_b_q.size() != 0 || exp_r_q.size() != 0 || w_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  // Upstream W driver, beats in AW order
  always @(posedge clk_i) begin : w_driver
    logic took;
    took = rst_ni && slv_w_valid_i && slv_w_ready_o;
    if (took) w_q.delete(0);
    #1;
    if (took) slv_w_valid_i = 1'b0;
    if (rst_ni && !slv_w_valid_i && w_q.size() > 0 && ($random(seed) & 3) != 0) begin
      slv_w_valid_i = 1'b1;
      {slv_w_last_i, slv_w_data_i} = w_q[0];
    end
  end

  // Upstream B and R monitors with random ready gaps
  always @(posedge clk_i) begin : resp_monitor
    if (rst_ni) begin
      if (slv_b_valid_o && slv_b_ready_i) check_b(slv_b_id_o, slv_b_resp_o);
      if (slv_r_valid_o && slv_r_ready_i) begin
        check_r(slv_r_id_o, slv_r_data_o, slv_r_resp_o, slv_r_last_o);
      end
      #1;
      slv_b_ready_i = ($random(seed) & 3) != 0;
      slv_r_ready_i = ($random(seed) & 3) != 0;
    end
  end

  // Downstream slave: in-order memory, always OKAY
  always @(posedge clk_i) begin : slave_model
    logic b_hs;
    logic r_hs;
    if (rst_ni) begin
      b_hs = mst_b_valid_i && mst_b_ready_o;
      r_hs = mst_r_valid_i && mst_r_ready_o;
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        // IDs 8 to 15 are only used by atomics
        if (mst_aw_id_o[3]) report_mismatch("atomic AW reached the slave");
        s_aw_q.push_back({mst_aw_id_o, mst_aw_addr_o, mst_aw_len_o});
        w_open++;
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (s_aw_q.size() == 0) report_mismatch("W beat reached the slave without an AW");
        s_mem[widx(s_aw_q[0][39:8], s_wbeat)] = mst_w_data_o;
        if (mst_w_last_o != (s_wbeat == int'(s_aw_q[0][7:0]))) begin
          report_mismatch("W last at the slave does not match the burst length");
        end
        if (mst_w_last_o) begin
          s_b_q.push_back(s_aw_q[0][43:40]);
          s_aw_q.delete(0);
          s_wbeat = 0;
          w_open--;
        end else begin
          s_wbeat++;
        end
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        s_ar_q.push_back({mst_ar_id_o, mst_ar_addr_o, mst_ar_len_o});
      end
      if (r_hs && mst_r_last_i) begin
        s_ar_q.delete(0);
        s_rbeat = 0;
      end else if (r_hs) begin
        s_rbeat++;
      end
      #1;
      mst_aw_ready_i = ($random(seed) & 3) != 0;
      mst_w_ready_i  = !hold_w && (($random(seed) & 3) != 0);
      mst_ar_ready_i = ($random(seed) & 3) != 0;
      if (b_hs) mst_b_valid_i = 1'b0;
      if (!mst_b_valid_i && s_b_q.size() > 0) begin
        mst_b_valid_i = 1'b1;
        mst_b_id_i    = s_b_q[0];
        mst_b_resp_i  = `ATOP_RESP_OKAY;
        s_b_q.delete(0);
      end
      if (r_hs) mst_r_valid_i = 1'b0;
      if (!mst_r_valid_i && s_ar_q.size() > 0) begin
        mst_r_valid_i = 1'b1;
        mst_r_id_i    = s_ar_q[0][43:40];
        mst_r_data_i  = s_mem[widx(s_ar_q[0][39:8], s_rbeat)];
        mst_r_resp_i  = `ATOP_RESP_OKAY;
        mst_r_last_i  = (s_rbeat == int'(s_ar_q[0][7:0]));
      end
    end
  end

  a_aw_atop_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_o |-> (mst_aw_atop_o == '0))
    else report_mismatch("downstream AW carries a non-zero atop");

  a_open_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_open <= `ATOP_MAX_WRITE_TXNS)
    else report_mismatch($sformatf("%0d downstream bursts with open W data", w_open));

  // Injected responses carry SLVERR and hold until taken
  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (slv_b_valid_o && !slv_b_ready_i && slv_b_resp_o == `ATOP_RESP_SLVERR) |=>
    (slv_b_valid_o && $stable(slv_b_id_o) && $stable(slv_b_resp_o)))
    else report_mismatch("injected B changed before its handshake");

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (slv_r_valid_o && !slv_r_ready_i && slv_r_resp_o == `ATOP_RESP_SLVERR) |=>
    (slv_r_valid_o && $stable(slv_r_id_o) && $stable(slv_r_data_o) &&
     $stable(slv_r_resp_o) && $stable(slv_r_last_o)))
    else report_mismatch("injected R beat changed before its handshake");

  initial begin : watchdog
    #(ClkPeriod * 200 * NumBursts);
    $display("Timeout: the run did not finish within %0d cycles", 200 * NumBursts);
    stop_run();
  end

  initial begin : main
    int         i;
    int         j;
    id_t        id;
    addr_t      addr;
    len_t       len;
    atop_t      atop;
    logic [1:0] kind;
    seed   = 32'h5e3a;
    hold_w = 1'b0;
    w_open = 0;
    s_wbeat = 0;
    s_rbeat = 0;
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    {slv_aw_valid_i, slv_aw_id_i, slv_aw_addr_i, slv_aw_len_i, slv_aw_atop_i} = '0;
    {slv_w_valid_i, slv_w_data_i, slv_w_last_i, slv_b_ready_i} = '0;
    {slv_ar_valid_i, slv_ar_id_i, slv_ar_addr_i, slv_ar_len_i, slv_r_ready_i} = '0;
    {mst_aw_ready_i, mst_w_ready_i, mst_ar_ready_i} = '0;
    {mst_b_valid_i, mst_b_id_i, mst_b_resp_i} = '0;
    {mst_r_valid_i, mst_r_id_i, mst_r_data_i, mst_r_resp_i, mst_r_last_i} = '0;
    for (i = 0; i < 256; i++) begin
      s_mem[i]   = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    if (slv_b_valid_o || slv_r_valid_o) report_mismatch("response valid high after reset");

    // Plain writes, then reads of the same words
    for (i = 0; i < 4; i++) write_burst(id_t'(i), addr_t'(32'h100 + i * 64), len_t'(i), '0);
    drain();
    for (i = 0; i < 4; i++) read_burst(id_t'(i), addr_t'(32'h100 + i * 64), len_t'(i));
    drain();

    // Atomic store, B only
    write_burst(4'h9, 32'h200, 8'd2, 6'h1a);
    drain();
    // Load, swap and compare
    write_burst(4'ha, 32'h240, 8'd3, 6'h21);
    write_burst(4'hb, 32'h260, 8'd0, 6'h30);
    write_burst(4'hc, 32'h280, 8'd1, 6'h31);
    drain();

    // Fill up to the limit with W blocked downstream
    hold_w = 1'b1;
    for (i = 0; i < `ATOP_MAX_WRITE_TXNS; i++) begin
      write_burst(id_t'(i), addr_t'(32'h300 + i * 16), 8'd1, '0);
    end
    fork
      write_burst(4'h7, 32'h380, 8'd0, '0);
      begin
        repeat (20) begin
          @(posedge clk_i);
          if (slv_aw_valid_i && slv_aw_ready_o) begin
            report_mismatch("upstream AW accepted with the write limit reached");
          end
        end
        hold_w = 1'b0;
      end
    join
    drain();

    // Atomics mixed with plain writes and reads
    fork
      for (i = 0; i < NumMixW; i++) begin
        len  = len_t'($random(seed) & 3);
        // Kept clear of the words read in parallel
        addr = addr_t'(32'h200 + i * 32);
        if (($random(seed) & 1) != 0) begin
          kind = 2'(1 + ($unsigned($random(seed)) % 3));
          atop = {kind, 4'($random(seed))};
          id   = id_t'(8 + ($random(seed) & 7));
        end else begin
          atop = '0;
          id   = id_t'($random(seed) & 7);
        end
        write_burst(id, addr, len, atop);
      end
      for (j = 0; j < NumMixR; j++) begin
        read_burst(id_t'($random(seed) & 7), addr_t'(32'h100 + ($random(seed) & 3) * 64),
                   len_t'($random(seed) & 3));
      end
    join
    drain();

    if (s_aw_q.size() != 0 || s_b_q.size() != 0 || w_open != 0) begin
      $display("Slave model still holds open write bursts at the end of the run");
      stop_run();
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

/* files.f */
+incdir+rtl
rtl/atop_filter_pkg.sv
rtl/atop_decode.sv
rtl/atop_write_ctrl.sv
rtl/atop_read_inject.sv
rtl/atop_filter_top.sv
sim/atop_filter_tb.sv
